//--- flist.f
logic/cpu_pkg.sv
logic/dp_ctrl_if.sv
logic/apb_instr_port.sv
logic/instr_queue.sv
logic/exec_ctrl.sv
logic/datapath.sv
logic/exec_core.sv
logic/cpu_top.sv
verification/cpu_checker.sv
verification/tb_top.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/Vtb_top | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/tb_top.sv
module tb_top import cpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int N_MOV      = 12;
  localparam int N_ALU      = 12;
  localparam int N_CMP      = 8;
  localparam int N_BURST    = 3;
  localparam int N_XFERS    = 16 + 2*N_MOV + 2*N_ALU + 6*N_CMP + 4 + 16*N_BURST + 11;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  word_t       pwdata;
  word_t       prdata;
  logic        pready;
  logic        pslverr;
  int          check_count;
  int          error_count;
  int          tb_errors;
  int          stall_cycles;   // write cycles spent waiting on pready
  logic [31:0] rng;

  cpu_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  cpu_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .check_count (check_count),
    .error_count (error_count)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  function automatic word_t enc_movi(input reg_idx_t rn, input logic [7:0] imm);
    return {OPC_MOV, OP_MOVI, rn, imm};
  endfunction

  function automatic word_t enc_reg(input opcode_t opc, input op_t op, input reg_idx_t rn,
                                    input reg_idx_t rd, input logic [1:0] sh,
                                    input reg_idx_t rm);
    return {opc, op, rn, rd, sh, rm};
  endfunction

  // entered and left on a falling edge, so transfers run back to back
  task automatic apb_transfer(input logic wr, input apb_addr_t addr, input word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready) begin
      if (wr)
        stall_cycles++;
      @(posedge clk);
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_instr(input word_t w);
    apb_transfer(1'b1, ADDR_INSTR, w);
  endtask

  task automatic read_reg(input reg_idx_t idx);
    apb_transfer(1'b0, ADDR_REG_BASE + apb_addr_t'(idx), '0);
  endtask

  task automatic read_flags();
    apb_transfer(1'b0, ADDR_FLAGS, '0);
  endtask

  initial begin
    logic [31:0] r;
    word_t       w;
    rng          = 32'd28028;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    tb_errors    = 0;
    stall_cycles = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 8; i++) begin   // load every register
      next_rand(r);
      write_instr(enc_movi(reg_idx_t'(i), r[7:0]));
    end
    for (int i = 0; i < 8; i++)
      read_reg(reg_idx_t'(i));

    for (int i = 0; i < N_MOV; i++) begin   // shift cycles through all four
      next_rand(r);
      if (r[11])
        w = enc_reg(OPC_ALU, OP_MVN, r[2:0], r[5:3], i[1:0], r[10:8]);
      else
        w = enc_reg(OPC_MOV, OP_MOV, r[2:0], r[5:3], i[1:0], r[10:8]);
      write_instr(w);
      read_reg(w[7:5]);
    end

    for (int i = 0; i < N_ALU; i++) begin
      next_rand(r);
      w = enc_reg(OPC_ALU, r[11] ? OP_AND : OP_ADD, r[2:0], r[5:3], r[7:6], r[10:8]);
      write_instr(w);
      read_reg(w[7:5]);
    end

    for (int i = 0; i < N_CMP; i++) begin
      next_rand(r);
      // first CMP compares a register with itself
      w = enc_reg(OPC_ALU, OP_CMP, r[2:0], r[5:3], (i == 0) ? 2'b00 : r[7:6],
                  (i == 0) ? r[2:0] : r[10:8]);
      write_instr(w);
      read_flags();
      read_reg(w[10:8]);
      read_reg(w[7:5]);   // Rd must keep its value
      next_rand(r);
      write_instr(enc_reg(OPC_ALU, OP_ADD, r[2:0], r[5:3], r[7:6], r[10:8]));
      read_flags();   // ADD leaves the flags alone
    end

    // large positive minus a negative, so V must be set
    write_instr(enc_movi(3'd0, 8'h80));
    write_instr(enc_reg(OPC_MOV, OP_MOV, 3'd0, 3'd1, 2'b10, 3'd0));   // R1 = R0 >> 1
    write_instr(enc_reg(OPC_ALU, OP_CMP, 3'd1, 3'd0, 2'b00, 3'd0));
    read_flags();

    stall_cycles = 0;
    for (int b = 0; b < N_BURST; b++) begin
      for (int k = 0; k < 8; k++) begin
        next_rand(r);
        write_instr(enc_reg(OPC_ALU, OP_ADD, r[2:0], r[5:3], r[7:6], r[10:8]));
      end
      for (int i = 0; i < 8; i++)
        read_reg(reg_idx_t'(i));
    end
    if (stall_cycles == 0) begin
      tb_errors++;
      $display("no instruction write stalled on pready during the ADD bursts");
    end

    next_rand(r);
    apb_transfer(1'b1, ADDR_FLAGS, r[15:0]);   // unmapped write
    apb_transfer(1'b0, ADDR_INSTR, '0);        // unmapped read
    for (int i = 0; i < 8; i++)
      read_reg(reg_idx_t'(i));
    read_flags();

    repeat (2) @(negedge clk);
    $display("transfers checked: %0d, checker errors: %0d, testbench errors: %0d",
             check_count, error_count, tb_errors);
    if (error_count + tb_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    #(N_XFERS * 200 * CLK_PERIOD);
    $display("watchdog: the run did not finish within %0d transfer slots", N_XFERS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verification/cpu_checker.sv
module cpu_checker import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  input  word_t     prdata,
  input  logic      pready,
  input  logic      pslverr,
  output int        check_count,
  output int        error_count
);
  timeunit 1ns;
  timeprecision 1ps;

  word_t  model_regs [8];   // written by the stimulus before any read
  flags_t model_flags;

  initial begin
    check_count = 0;
    error_count = 0;
    model_flags = '0;
    for (int i = 0; i < 8; i++)
      model_regs[i] = '0;
  end

  function automatic word_t shifted(input word_t v, input logic [1:0] sh);
    case (shift_t'(sh))
      SH_LSL:  return v << 1;
      SH_LSR:  return v >> 1;
      SH_ASR:  return word_t'($signed(v) >>> 1);
      default: return v;
    endcase
  endfunction

  task automatic compare(input string name, input word_t exp, input word_t got);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %0t %s: expected 0x%04h got 0x%04h", $time, name, exp, got);
    end
  endtask

  task automatic apply_instr(input word_t w);
    word_t a;
    word_t b;
    int    diff;
    a = model_regs[w[10:8]];                  // Rn
    b = shifted(model_regs[w[2:0]], w[4:3]);  // shifted Rm
    if (w[15:13] == OPC_MOV && w[12:11] == OP_MOVI)
      model_regs[w[10:8]] = {{8{w[7]}}, w[7:0]};
    else if (w[15:13] == OPC_MOV && w[12:11] == OP_MOV)
      model_regs[w[7:5]] = b;
    else if (w[15:13] == OPC_ALU) begin
      case (w[12:11])
        OP_MVN: model_regs[w[7:5]] = ~b;
        OP_ADD: model_regs[w[7:5]] = a + b;   // wraps at 16 bits
        OP_AND: model_regs[w[7:5]] = a & b;
        default: begin
          diff = $signed(a) - $signed(b);     // CMP, full precision
          model_flags[FLAG_Z] = (diff[15:0] == 16'h0000);
          model_flags[FLAG_N] = diff[15];
          model_flags[FLAG_V] = (diff > 32767) || (diff < -32768);
        end
      endcase
    end
  endtask

  task automatic check_transfer();
    logic bad;
    bad = !((pwrite && paddr == ADDR_INSTR) ||
            (!pwrite && (paddr == ADDR_FLAGS || paddr >= ADDR_REG_BASE)));
    compare("pslverr", word_t'(bad), word_t'(pslverr));
    if (!bad && pwrite)
      apply_instr(pwdata);
    else if (!bad && paddr == ADDR_FLAGS)
      compare("prdata (flags)", word_t'(model_flags), prdata);
    else if (!bad)
      compare($sformatf("prdata (R%0d)", paddr - ADDR_REG_BASE),
              model_regs[paddr - ADDR_REG_BASE], prdata);
  endtask

  always @(posedge clk) begin
    if (!rst_n)
      model_flags = '0;
    else if (psel && penable && pready)   // transfer ends this edge
      check_transfer();
  end

endmodule

//--- logic/cpu_top.sv
module cpu_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr
);

  logic     push;
  word_t    push_data;
  logic     full;
  logic     valid;
  word_t    instr;
  logic     pop;
  logic     empty;
  logic     idle;
  reg_idx_t dbg_idx;
  word_t    dbg_data;
  flags_t   flags;

  apb_instr_port u_apb (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .idle      (idle),
    .dbg_idx   (dbg_idx),
    .dbg_data  (dbg_data),
    .flags     (flags)
  );

  instr_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .valid     (valid),
    .instr     (instr),
    .pop       (pop),
    .empty     (empty)
  );

  exec_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid    (valid),
    .instr    (instr),
    .pop      (pop),
    .empty    (empty),
    .idle     (idle),
    .dbg_idx  (dbg_idx),
    .dbg_data (dbg_data),
    .flags    (flags)
  );

endmodule

//--- logic/exec_core.sv
module exec_core import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid,
  input  word_t    instr,
  output logic     pop,
  input  logic     empty,
  output logic     idle,
  input  reg_idx_t dbg_idx,
  output word_t    dbg_data,
  output flags_t   flags
);

  dp_ctrl_if bus ();

  word_t ir_q;
  word_t ir;
  word_t imm8_sx;
  logic  busy;

  always_ff @(posedge clk) begin
    if (pop)
      ir_q <= instr;              // current instruction
  end

  // decode sees the queue head while idle so dispatch costs no cycle
  assign ir      = busy ? ir_q : instr;
  assign imm8_sx = {{(WORD_W-IMM8_MSB-1){ir_q[IMM8_MSB]}}, ir_q[IMM8_MSB:IMM8_LSB]};
  assign idle    = empty && !busy;
  assign flags   = bus.flags;

  exec_ctrl u_ctrl (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (valid),
    .pop   (pop),
    .ir    (ir),
    .busy  (busy),
    .ctrl  (bus.ctrl)
  );

  datapath u_dp (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (bus.dp),
    .imm8     (imm8_sx),
    .dbg_idx  (dbg_idx),
    .dbg_data (dbg_data)
  );

endmodule

//--- logic/datapath.sv
module datapath import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  dp_ctrl_if.dp    ctrl,
  input  word_t    imm8,
  input  reg_idx_t dbg_idx,
  output word_t    dbg_data
);

  word_t  regs [NUM_REGS];
  word_t  rdata;
  word_t  wb_data;
  word_t  a_q;
  word_t  b_q;
  word_t  c_q;
  flags_t flags_q;
  word_t  a_val;
  word_t  b_sh;
  word_t  b_add;
  word_t  sum;
  word_t  alu_y;
  logic   sub;
  logic   ovf;
  flags_t flags_nxt;

  assign rdata    = regs[ctrl.read_idx];
  assign dbg_data = regs[dbg_idx];     // host read port
  assign wb_data  = (ctrl.wb_sel == WB_IMM) ? imm8 : c_q;

  always_ff @(posedge clk) begin
    if (ctrl.write_en)
      regs[ctrl.write_idx] <= wb_data;
    if (ctrl.load_a)
      a_q <= rdata;
    if (ctrl.load_b)
      b_q <= rdata;
    if (ctrl.load_c)
      c_q <= alu_y;
  end

  // shifter on B
  always_comb begin
    case (ctrl.shift)
      SH_LSL:  b_sh = {b_q[WORD_W-2:0], 1'b0};
      SH_LSR:  b_sh = {1'b0, b_q[WORD_W-1:1]};
      SH_ASR:  b_sh = {b_q[WORD_W-1], b_q[WORD_W-1:1]};
      default: b_sh = b_q;
    endcase
  end

  assign a_val = ctrl.zero_a ? '0 : a_q;
  assign sub   = (ctrl.alu_op == ALU_SUB);
  assign b_add = sub ? ~b_sh : b_sh;    // two's complement with carry in
  assign sum   = a_val + b_add + word_t'(sub);
  assign ovf   = (a_val[WORD_W-1] == b_add[WORD_W-1]) &&
                 (sum[WORD_W-1] != a_val[WORD_W-1]);

  always_comb begin
    case (ctrl.alu_op)
      ALU_AND: alu_y = a_val & b_sh;
      ALU_NOT: alu_y = ~b_sh;
      default: alu_y = sum;
    endcase
  end

  always_comb begin
    flags_nxt         = '0;
    flags_nxt[FLAG_Z] = (alu_y == '0);
    flags_nxt[FLAG_N] = alu_y[WORD_W-1];
    flags_nxt[FLAG_V] = ovf && (ctrl.alu_op inside {ALU_ADD, ALU_SUB});
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      flags_q <= '0;
    else if (ctrl.load_flags)
      flags_q <= flags_nxt;
  end

  assign ctrl.flags = flags_q;

endmodule

//--- logic/exec_ctrl.sv
module exec_ctrl import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      valid,
  output logic      pop,
  input  word_t     ir,
  output logic      busy,
  dp_ctrl_if.ctrl   ctrl
);

  exec_state_t state;
  exec_state_t state_nxt;
  opcode_t     opcode;
  op_t         op;
  reg_idx_t    rn;
  reg_idx_t    rd;
  reg_idx_t    rm;
  logic        is_movi;
  logic        is_mov;
  logic        is_mvn;
  logic        is_add;
  logic        is_and;
  logic        is_cmp;

  assign opcode = ir[OPC_MSB:OPC_LSB];
  assign op     = ir[OP_MSB:OP_LSB];
  assign rn     = ir[RN_MSB:RN_LSB];
  assign rd     = ir[RD_MSB:RD_LSB];
  assign rm     = ir[RM_MSB:RM_LSB];

  assign is_movi = (opcode == OPC_MOV) && (op == OP_MOVI);
  assign is_mov  = (opcode == OPC_MOV) && (op == OP_MOV);
  assign is_mvn  = (opcode == OPC_ALU) && (op == OP_MVN);
  assign is_add  = (opcode == OPC_ALU) && (op == OP_ADD);
  assign is_and  = (opcode == OPC_ALU) && (op == OP_AND);
  assign is_cmp  = (opcode == OPC_ALU) && (op == OP_CMP);

  assign busy = (state != S_IDLE);
  assign pop  = valid && !busy;      // take the head word when idle

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (valid) begin
          if (is_movi)
            state_nxt = S_MOVI;
          else if (is_mov || is_mvn)
            state_nxt = S_LOAD_B;   // no Rn operand
          else if (is_add || is_and || is_cmp)
            state_nxt = S_LOAD_A;
          // unknown words retire here
        end
      end
      S_MOVI:    state_nxt = S_IDLE;
      S_LOAD_A:  state_nxt = S_LOAD_B;
      S_LOAD_B:  state_nxt = S_COMPUTE;
      S_COMPUTE: state_nxt = S_WRITE;
      S_WRITE:   state_nxt = S_IDLE;
      default:   state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      state <= S_IDLE;
    else
      state <= state_nxt;
  end

  // datapath controls
  assign ctrl.read_idx   = (state == S_LOAD_A) ? rn : rm;
  assign ctrl.load_a     = (state == S_LOAD_A);
  assign ctrl.load_b     = (state == S_LOAD_B);
  assign ctrl.load_c     = (state == S_COMPUTE);
  assign ctrl.load_flags = (state == S_COMPUTE) && is_cmp;
  assign ctrl.zero_a     = is_mov || is_mvn;
  assign ctrl.shift      = shift_t'(ir[SH_MSB:SH_LSB]);
  assign ctrl.write_idx  = (state == S_MOVI) ? rn : rd;
  assign ctrl.write_en   = (state == S_MOVI) || ((state == S_WRITE) && !is_cmp);
  assign ctrl.wb_sel     = (state == S_MOVI) ? WB_IMM : WB_C;

  always_comb begin
    if (is_mvn)
      ctrl.alu_op = ALU_NOT;
    else if (is_and)
      ctrl.alu_op = ALU_AND;
    else if (is_cmp)
      ctrl.alu_op = ALU_SUB;
    else
      ctrl.alu_op = ALU_ADD;   // ADD, and MOV with A forced to zero
  end

  a_state_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    state inside {S_IDLE, S_MOVI, S_LOAD_A, S_LOAD_B, S_COMPUTE, S_WRITE}
  ) else $error("exec_ctrl: illegal state %0d", state);

endmodule

//--- logic/instr_queue.sv
module instr_queue import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push,
  input  word_t push_data,
  output logic  full,
  output logic  valid,
  output word_t instr,
  input  logic  pop,
  output logic  empty
);

  word_t mem [QUEUE_DEPTH];
  qptr_t wr_ptr;
  qptr_t rd_ptr;
  qcnt_t count;
  logic  do_push;
  logic  do_pop;

  function automatic qptr_t ptr_inc(qptr_t p);
    if (p == qptr_t'(QUEUE_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == qcnt_t'(QUEUE_DEPTH));
  assign empty = (count == '0);
  assign valid = !empty;
  assign instr = mem[rd_ptr];      // head of queue

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
    end
  end

  a_no_push_full : assert property (
    @(posedge clk) disable iff (!rst_n) push |-> !full
  ) else $error("instr_queue: push while full");

  a_no_pop_empty : assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  ) else $error("instr_queue: pop while empty");

endmodule

//--- logic/apb_instr_port.sv
module apb_instr_port import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  word_t     pwdata,
  output word_t     prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      push,
  output word_t     push_data,
  input  logic      full,
  input  logic      idle,
  output reg_idx_t  dbg_idx,
  input  word_t     dbg_data,
  input  flags_t    flags
);

  logic access;
  logic is_instr;
  logic is_flags;
  logic is_reg;
  logic legal_wr;
  logic legal_rd;
  logic bad_acc;

  assign access   = psel && penable;
  assign is_instr = (paddr == ADDR_INSTR);
  assign is_flags = (paddr == ADDR_FLAGS);
  assign is_reg   = (paddr >= ADDR_REG_BASE);   // R0..R7 at 8..15

  assign legal_wr = pwrite && is_instr;
  assign legal_rd = !pwrite && (is_flags || is_reg);
  assign bad_acc  = !(legal_wr || legal_rd);

  // a queued write needs a free slot
  assign push      = access && legal_wr && !full;
  assign push_data = pwdata;

  // reads wait until every earlier instruction has retired
  always_comb begin
    pready = 1'b0;
    if (access) begin
      if (bad_acc)
        pready = 1'b1;
      else if (legal_wr)
        pready = !full;
      else
        pready = idle;
    end
  end

  assign pslverr = access && bad_acc;

  assign dbg_idx = reg_idx_t'(paddr - ADDR_REG_BASE);

  always_comb begin
    if (is_reg)
      prdata = dbg_data;
    else if (is_flags)
      prdata = word_t'(flags);   // zero-extended
    else
      prdata = '0;
  end

  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  ) else $error("apb: penable high without psel");

endmodule

//--- logic/dp_ctrl_if.sv
interface dp_ctrl_if import cpu_pkg::*; ();

  reg_idx_t read_idx;     // operand read port
  reg_idx_t write_idx;
  logic     write_en;
  wb_sel_t  wb_sel;
  logic     load_a;
  logic     load_b;
  logic     zero_a;       // force A operand to zero
  logic     load_c;
  logic     load_flags;
  shift_t   shift;
  alu_op_t  alu_op;
  flags_t   flags;        // back from the datapath

  modport ctrl (
    output read_idx, write_idx, write_en, wb_sel, load_a, load_b,
    output zero_a, load_c, load_flags, shift, alu_op,
    input  flags
  );

  modport dp (
    input  read_idx, write_idx, write_en, wb_sel, load_a, load_b,
    input  zero_a, load_c, load_flags, shift, alu_op,
    output flags
  );

endinterface

//--- logic/cpu_pkg.sv
package cpu_pkg;

  localparam int WORD_W     = 16;
  localparam int REG_IDX_W  = 3;
  localparam int NUM_REGS   = 8;
  localparam int FLAG_W     = 3;
  localparam int APB_ADDR_W = 4;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [FLAG_W-1:0]     flags_t;    // {V, N, Z}
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [2:0]            opcode_t;
  typedef logic [1:0]            op_t;

  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 2;

  // instruction fields
  localparam int OPC_MSB  = 15;
  localparam int OPC_LSB  = 13;
  localparam int OP_MSB   = 12;
  localparam int OP_LSB   = 11;
  localparam int RN_MSB   = 10;
  localparam int RN_LSB   = 8;
  localparam int RD_MSB   = 7;
  localparam int RD_LSB   = 5;
  localparam int SH_MSB   = 4;
  localparam int SH_LSB   = 3;
  localparam int RM_MSB   = 2;
  localparam int RM_LSB   = 0;
  localparam int IMM8_MSB = 7;
  localparam int IMM8_LSB = 0;

  localparam opcode_t OPC_MOV = 3'b110;
  localparam opcode_t OPC_ALU = 3'b101;
  localparam op_t     OP_MOVI = 2'b10;   // with OPC_MOV
  localparam op_t     OP_MOV  = 2'b00;   // with OPC_MOV
  localparam op_t     OP_MVN  = 2'b11;
  localparam op_t     OP_ADD  = 2'b00;
  localparam op_t     OP_AND  = 2'b10;
  localparam op_t     OP_CMP  = 2'b01;

  // APB register map, word addresses
  localparam apb_addr_t ADDR_INSTR    = 4'd0;
  localparam apb_addr_t ADDR_FLAGS    = 4'd1;
  localparam apb_addr_t ADDR_REG_BASE = 4'd8;

  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QPTR_W:0]   qcnt_t;

  typedef enum logic [1:0] {SH_NONE, SH_LSL, SH_LSR, SH_ASR} shift_t;
  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_NOT} alu_op_t;
  typedef enum logic {WB_C, WB_IMM} wb_sel_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_MOVI,
    S_LOAD_A,
    S_LOAD_B,
    S_COMPUTE,
    S_WRITE
  } exec_state_t;

endpackage
